// File: build.f
logic/fp_add_pkg.sv
logic/leading_zero_counter.sv
logic/fp_operand_compare.sv
logic/fp_mantissa_align.sv
logic/fp_mantissa_add.sv
logic/fp_normalize.sv
logic/fp_adder.sv
verification/fp_adder_chk.sv
verification/fp_adder_tb.sv

// File: Bender.yml
package:
  name: fp_adder

sources:
  - files:
      - logic/fp_add_pkg.sv
      - logic/leading_zero_counter.sv
      - logic/fp_operand_compare.sv
      - logic/fp_mantissa_align.sv
      - logic/fp_mantissa_add.sv
      - logic/fp_normalize.sv
      - logic/fp_adder.sv
  - target: test
    files:
      - verification/fp_adder_chk.sv
      - verification/fp_adder_tb.sv

// File: verification/fp_adder_tb.sv
`timescale 1ns/1ns

module fp_adder_tb import fp_add_pkg::*; ();

    localparam int       NUM_OPS    = 240;
    localparam int       CLK_PERIOD = 40;
    localparam int       FIXED_OPS  = 5;
    localparam float32_t POS_INF    = 32'h7f80_0000;
    localparam float32_t NEG_INF    = 32'hff80_0000;

    logic        clk = 1'b0;
    logic        rst_n;
    float32_t    addend_a;
    float32_t    addend_b;
    fp_op_t      operation;
    logic        data_valid_in;
    logic        data_valid_out;
    logic        invalid_operation;
    logic        overflow;
    logic        underflow;
    float32_t    result;
    logic [31:0] lcg_state;
    int unsigned ops_sent;
    int unsigned results_seen = 0;
    int unsigned error_total;

    fp_adder fp_adder_i (
        .clk_i               (clk),
        .rst_n_i             (rst_n),
        .addend_a_i          (addend_a),
        .addend_b_i          (addend_b),
        .operation_i         (operation),
        .data_valid_i        (data_valid_in),
        .data_valid_o        (data_valid_out),
        .invalid_operation_o (invalid_operation),
        .overflow_o          (overflow),
        .underflow_o         (underflow),
        .result_o            (result)
    );

    bind fp_adder fp_adder_chk fp_adder_chk_i (.*);

    always begin
        #(CLK_PERIOD / 2);
        clk = ~clk;
    end

    always @(negedge clk) begin
        if (data_valid_out === 1'b1) begin
            results_seen <= results_seen + 1; // outputs are settled mid-cycle.
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_random(output logic [31:0] value);
        lcg_state = lcg_next(lcg_state);
        value = lcg_state;
    endtask

    task automatic drive_op(input float32_t a, input float32_t b, input fp_op_t op);
        @(negedge clk);
        addend_a      = a;
        addend_b      = b;
        operation     = op;
        data_valid_in = 1'b1;
        ops_sent++;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        data_valid_in = 1'b0;
    endtask

    // picks a case from the top bits and masks the fields to reach it.
    task automatic random_op();
        logic [31:0] r;
        logic [31:0] s;
        float32_t    a;
        float32_t    b;
        fp_op_t      op;
        next_random(r);
        next_random(s);
        a  = s;
        b  = r;
        op = fp_op_t'(r[31]);
        case (r[30:28])
            3'd0: begin
                if (r[25]) begin
                    b.exponent    = '1;
                    b.mantissa[0] = 1'b1;
                end else begin
                    a.exponent    = '1;
                    a.mantissa[0] = 1'b1;
                end
            end
            3'd1: begin
                a = r[27] ? NEG_INF : POS_INF;
                b = r[26] ? NEG_INF : POS_INF;
            end
            3'd2: begin
                a.exponent = 8'(s[15:8] % 8'd253) + 8'd1;
                b = {a.sign ^ (op == SUB), a.exponent, a.mantissa};
            end
            3'd3: begin // doubling right at the largest exponent.
                a.exponent = MAX_EXP;
                b = {a.sign ^ (op == SUB), a.exponent, a.mantissa};
            end
            3'd4: begin
                a.exponent = 8'd24 + 8'(s[15:8] % 8'd230);
                b  = '0;
                op = ADD;
            end
            default: begin // close exponents give cancellations.
                a.exponent = {1'b0, s[29:23]} + 8'd64;
                b.exponent = a.exponent ^ {5'd0, r[2:0]};
            end
        endcase
        if (r[30:28] == 3'd5) begin
            idle_cycle();
        end else begin
            drive_op(a, b, op);
        end
    endtask

    initial begin
        #((NUM_OPS + 10) * CLK_PERIOD);
        $display("timeout: the adder did not return every result in time");
        $display("test failed");
        $finish;
    end

    initial begin
        lcg_state     = 32'ha2fc;
        ops_sent      = 0;
        rst_n         = 1'b0;
        addend_a      = '0;
        addend_b      = '0;
        operation     = ADD;
        data_valid_in = 1'b1; // strobes during reset must never reach the output.
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n         = 1'b1;
        data_valid_in = 1'b0;

        drive_op(POS_INF, POS_INF, SUB);
        drive_op(POS_INF, NEG_INF, ADD);
        drive_op(POS_INF, POS_INF, ADD);
        drive_op(32'h7fc0_0001, 32'h3f80_0000, ADD);
        drive_op(32'h4040_0000, 32'hff80_0001, SUB);
        repeat (NUM_OPS - FIXED_OPS) random_op();
        idle_cycle();

        wait (results_seen == ops_sent);
        @(posedge clk); // the last result is checked on this edge.
        @(negedge clk);
        error_total = fp_adder_i.fp_adder_chk_i.error_count;
        $display("summary: %0d operations, %0d results, %0d errors",
                 ops_sent, results_seen, error_total);
        if (error_total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : fp_adder_tb

// File: verification/fp_adder_chk.sv
`timescale 1ns/1ns

module fp_adder_chk import fp_add_pkg::*; (
    input logic     clk_i,
    input logic     rst_n_i,
    input float32_t addend_a_i,
    input float32_t addend_b_i,
    input fp_op_t   operation_i,
    input logic     data_valid_i,
    input logic     data_valid_o,
    input logic     invalid_operation_o,
    input logic     overflow_o,
    input logic     underflow_o,
    input float32_t result_o
);

    int unsigned       error_count = 0;
    float32_t          a_hist [STAGES];
    float32_t          b_hist [STAGES];
    fp_op_t            op_hist [STAGES];
    logic [STAGES-1:0] dv_hist;
    float32_t          a_d;
    float32_t          b_d;
    logic              inv_exp;
    logic              doubling;
    logic              zero_add;
    float32_t          dbl_exp;

    function automatic logic is_nan(input float32_t f);
        return (f.exponent == '1) && (f.mantissa != '0);
    endfunction

    function automatic logic is_inf(input float32_t f);
        return (f.exponent == '1) && (f.mantissa == '0);
    endfunction

    // inputs as they were when the current output entered the pipeline.
    always_ff @(posedge clk_i) begin
        a_hist[0]  <= addend_a_i;
        b_hist[0]  <= addend_b_i;
        op_hist[0] <= operation_i;
        dv_hist    <= {dv_hist[STAGES-2:0], data_valid_i};
        for (int i = 1; i < STAGES; i++) begin
            a_hist[i]  <= a_hist[i-1];
            b_hist[i]  <= b_hist[i-1];
            op_hist[i] <= op_hist[i-1];
        end
    end

    assign a_d = a_hist[STAGES-1];
    assign b_d = b_hist[STAGES-1];

    // effective sign of b decides whether two infinities cancel.
    assign inv_exp = is_nan(a_d) || is_nan(b_d) || (is_inf(a_d) && is_inf(b_d) &&
                     (a_d.sign ^ b_d.sign ^ (op_hist[STAGES-1] == SUB)));
    assign doubling = (a_d.exponent != '0) && (a_d.exponent != '1) &&
                      (b_d == {a_d.sign ^ (op_hist[STAGES-1] == SUB), a_d.exponent, a_d.mantissa});
    assign zero_add = (a_d.exponent >= 8'd24) && (a_d.exponent != '1) && (b_d == '0) &&
                      (op_hist[STAGES-1] == ADD);
    assign dbl_exp = (a_d.exponent == MAX_EXP) ? a_d :
                     {a_d.sign, a_d.exponent + 8'd1, a_d.mantissa}; // saturates at the top.

    reset_quiet: assert property (@(posedge clk_i) !rst_n_i |=> !data_valid_o [*4])
        else begin
            error_count++;
            $error("ERROR at %0t: data_valid_o expected 0, actual %b", $time,
                   $sampled(data_valid_o));
        end

    valid_delay: assert property (@(posedge clk_i)
        rst_n_i [*5] |-> data_valid_o == dv_hist[STAGES-1])
        else begin
            error_count++;
            $error("ERROR at %0t: data_valid_o expected %b, actual %b", $time,
                   $sampled(dv_hist[STAGES-1]), $sampled(data_valid_o));
        end

    invalid_nan: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_valid_o && inv_exp |-> invalid_operation_o && result_o == CANONICAL_NAN)
        else begin
            error_count++;
            $error("ERROR at %0t: result_o expected %h, actual %h, invalid_operation_o %b",
                   $time, CANONICAL_NAN, $sampled(result_o), $sampled(invalid_operation_o));
        end

    valid_operation: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_valid_o && !inv_exp |-> !invalid_operation_o)
        else begin
            error_count++;
            $error("ERROR at %0t: invalid_operation_o expected 0, actual %b", $time,
                   $sampled(invalid_operation_o));
        end

    doubled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_valid_o && doubling |->
        result_o == dbl_exp && overflow_o == (a_d.exponent == MAX_EXP) && !underflow_o)
        else begin
            error_count++;
            $error("ERROR at %0t: result_o expected %h, actual %h, overflow_o expected %b, actual %b",
                   $time, $sampled(dbl_exp), $sampled(result_o),
                   $sampled(a_d.exponent == MAX_EXP), $sampled(overflow_o));
        end

    zero_sum: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_valid_o && zero_add |-> result_o == a_d && !overflow_o && !underflow_o)
        else begin
            error_count++;
            $error("ERROR at %0t: result_o expected %h, actual %h", $time,
                   $sampled(a_d), $sampled(result_o));
        end

endmodule : fp_adder_chk

// File: logic/fp_adder.sv
`timescale 1ns/1ns

module fp_adder import fp_add_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  float32_t addend_a_i,
    input  float32_t addend_b_i,
    input  fp_op_t   operation_i,
    input  logic     data_valid_i,
    output logic     data_valid_o,
    output logic     invalid_operation_o,
    output logic     overflow_o,
    output logic     underflow_o,
    output float32_t result_o
);

    logic [STAGES-1:0] valid_pipe; // one bit per stage.
    cmp_stage_t        cmp_stage;
    align_stage_t      align_stage;
    sum_stage_t        sum_stage;
    norm_stage_t       norm_stage;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[STAGES-2:0], data_valid_i};
        end
    end

    assign data_valid_o = valid_pipe[STAGES-1];

    fp_operand_compare fp_operand_compare_i (
        .clk_i       (clk_i),
        .addend_a_i  (addend_a_i),
        .addend_b_i  (addend_b_i),
        .operation_i (operation_i),
        .cmp_o       (cmp_stage)
    );

    fp_mantissa_align fp_mantissa_align_i (
        .clk_i   (clk_i),
        .cmp_i   (cmp_stage),
        .align_o (align_stage)
    );

    fp_mantissa_add fp_mantissa_add_i (
        .clk_i   (clk_i),
        .align_i (align_stage),
        .sum_o   (sum_stage)
    );

    fp_normalize fp_normalize_i (
        .clk_i  (clk_i),
        .sum_i  (sum_stage),
        .norm_o (norm_stage)
    );

    // invalid results always leave as the quiet nan.
    assign result_o            = norm_stage.invalid ? CANONICAL_NAN : norm_stage.result;
    assign invalid_operation_o = norm_stage.invalid;
    assign overflow_o          = norm_stage.overflow;
    assign underflow_o         = norm_stage.underflow;

endmodule : fp_adder

// File: logic/fp_normalize.sv
`timescale 1ns/1ns

module fp_normalize import fp_add_pkg::*; (
    input  logic        clk_i,
    input  sum_stage_t  sum_i,
    output norm_stage_t norm_o
);

    logic [SIG_W-1:0]   significand;
    logic [LZC_W-1:0]   leading_zeros;
    logic [EXP_W:0]     exp_lowered;   // msb set means it went negative.
    logic [EXP_W-1:0]   under_shift;
    logic [SIG_W-1:0]   sig_right;
    logic [2*SIG_W-1:0] wide_shifted;
    float32_t           result;
    logic               overflow;
    logic               underflow;

    assign significand = {sum_i.hidden, sum_i.result.mantissa};

    leading_zero_counter leading_zero_counter_i (
        .operand_i (significand),
        .count_o   (leading_zeros)
    );

    assign exp_lowered = {1'b0, sum_i.result.exponent} -
                         {{(EXP_W + 1 - LZC_W){1'b0}}, leading_zeros};

    // shift as far as the exponent allows before hitting MIN_EXP.
    assign under_shift = (sum_i.result.exponent > MIN_EXP) ?
                         sum_i.result.exponent - MIN_EXP : '0;

    assign sig_right = significand >> 1;

    always_comb begin
        result       = sum_i.result;
        overflow     = 1'b0;
        underflow    = 1'b0;
        wide_shifted = '0;

        case ({sum_i.carry && !sum_i.signs_diff, (leading_zeros != '0) && sum_i.signs_diff})
            2'b10: begin // carry out of an addition.
                result.mantissa = sig_right[MANT_W-1:0];
                if (sum_i.result.exponent == MAX_EXP) begin
                    overflow = 1'b1;
                end else begin
                    result.exponent = sum_i.result.exponent + 1'b1;
                end
            end

            2'b01: begin // cancellation after a subtraction.
                if (exp_lowered[EXP_W] || (exp_lowered == '0)) begin
                    wide_shifted    = {significand, sum_i.shifted_out} << under_shift;
                    result.exponent = MIN_EXP;
                    underflow       = 1'b1;
                end else begin
                    wide_shifted    = {significand, sum_i.shifted_out} << leading_zeros;
                    result.exponent = exp_lowered[EXP_W-1:0];
                end
                result.mantissa = wide_shifted[2*SIG_W-2:SIG_W]; // drop the hidden bit.
            end

            default: begin
                result = sum_i.result;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        norm_o.result    <= result;
        norm_o.overflow  <= overflow;
        norm_o.underflow <= underflow;
        norm_o.invalid   <= sum_i.invalid;
    end

endmodule : fp_normalize

// File: logic/fp_mantissa_add.sv
`timescale 1ns/1ns

module fp_mantissa_add import fp_add_pkg::*; (
    input  logic         clk_i,
    input  align_stage_t align_i,
    output sum_stage_t   sum_o
);

    logic               major_hidden;
    logic signed [SIG_W+1:0] major_signed; // two extra bits, sign and carry.
    logic signed [SIG_W+1:0] minor_signed;
    logic signed [SIG_W+1:0] sum;
    logic [SIG_W+1:0]   magnitude;
    logic               signs_diff;

    assign major_hidden = (align_i.major.exponent != '0);

    // two's complement form of each operand from its sign.
    always_comb begin
        major_signed = $signed({2'b00, major_hidden, align_i.major.mantissa});
        minor_signed = $signed({2'b00, align_i.minor_aligned});

        if (align_i.major.sign) begin
            major_signed = -major_signed;
        end
        if (align_i.minor_sign) begin
            minor_signed = -minor_signed;
        end
    end

    assign sum = major_signed + minor_signed;

    // result takes the major sign, so flip back when it is negative.
    assign magnitude = align_i.major.sign ? -sum : sum;

    assign signs_diff = align_i.major.sign ^ align_i.minor_sign;

    always_ff @(posedge clk_i) begin
        sum_o.result.sign     <= align_i.major.sign;
        sum_o.result.exponent <= align_i.major.exponent;
        sum_o.result.mantissa <= magnitude[MANT_W-1:0];
        sum_o.hidden          <= magnitude[MANT_W];
        sum_o.carry           <= magnitude[SIG_W] && !signs_diff; // only a true addition.
        sum_o.signs_diff      <= signs_diff;
        sum_o.shifted_out     <= align_i.shifted_out;
        sum_o.invalid         <= align_i.invalid;
    end

endmodule : fp_mantissa_add

// File: logic/fp_mantissa_align.sv
`timescale 1ns/1ns

module fp_mantissa_align import fp_add_pkg::*; (
    input  logic         clk_i,
    input  cmp_stage_t   cmp_i,
    output align_stage_t align_o
);

    logic [2*SIG_W-1:0] shifted; // upper half aligned, lower half fell out.

    // everything falls out once the difference reaches the full width.
    always_comb begin
        if (cmp_i.exp_diff >= EXP_W'(SIG_W)) begin
            shifted = '0;
        end else begin
            shifted = {cmp_i.minor_hidden, cmp_i.minor_mantissa, {SIG_W{1'b0}}}
                      >> cmp_i.exp_diff;
        end
    end

    always_ff @(posedge clk_i) begin
        align_o.major         <= cmp_i.major;
        align_o.minor_sign    <= cmp_i.minor_sign;
        align_o.minor_aligned <= shifted[2*SIG_W-1:SIG_W];
        align_o.shifted_out   <= shifted[SIG_W-1:0]; // kept for the left shift later.
        align_o.invalid       <= cmp_i.invalid;
    end

endmodule : fp_mantissa_align

// File: logic/fp_operand_compare.sv
`timescale 1ns/1ns

module fp_operand_compare import fp_add_pkg::*; (
    input  logic       clk_i,
    input  float32_t   addend_a_i,
    input  float32_t   addend_b_i,
    input  fp_op_t     operation_i,
    output cmp_stage_t cmp_o
);

    logic             a_is_inf;
    logic             b_is_inf;
    logic             a_is_nan;
    logic             b_is_nan;
    float32_t         b_eff;     // b as it is actually added.
    logic [EXP_W:0]   exp_sub;   // one extra bit for the borrow.
    float32_t         major;
    float32_t         minor;
    logic [EXP_W-1:0] exp_diff_abs;
    logic             invalid;

    assign a_is_inf = (addend_a_i.exponent == '1) && (addend_a_i.mantissa == '0);
    assign b_is_inf = (addend_b_i.exponent == '1) && (addend_b_i.mantissa == '0);
    assign a_is_nan = (addend_a_i.exponent == '1) && (addend_a_i.mantissa != '0);
    assign b_is_nan = (addend_b_i.exponent == '1) && (addend_b_i.mantissa != '0);

    // subtraction is an addition with b negated.
    always_comb begin
        b_eff      = addend_b_i;
        b_eff.sign = addend_b_i.sign ^ (operation_i == SUB);
    end

    assign exp_sub = {1'b0, addend_a_i.exponent} - {1'b0, addend_b_i.exponent};

    always_comb begin
        if (exp_sub[EXP_W]) begin // b has the larger exponent.
            major        = b_eff;
            minor        = addend_a_i;
            exp_diff_abs = addend_b_i.exponent - addend_a_i.exponent;
        end else begin
            major        = addend_a_i;
            minor        = b_eff;
            exp_diff_abs = exp_sub[EXP_W-1:0];
        end
    end

    // inf - inf or any nan input.
    assign invalid = a_is_nan || b_is_nan ||
                     (a_is_inf && b_is_inf && (addend_a_i.sign ^ b_eff.sign));

    always_ff @(posedge clk_i) begin
        cmp_o.major          <= major;
        cmp_o.minor_sign     <= minor.sign;
        cmp_o.minor_hidden   <= (minor.exponent != '0); // zero exponent means denormal.
        cmp_o.minor_mantissa <= minor.mantissa;
        cmp_o.exp_diff       <= exp_diff_abs;
        cmp_o.invalid        <= invalid;
    end

endmodule : fp_operand_compare

// File: logic/leading_zero_counter.sv
`timescale 1ns/1ns

module leading_zero_counter import fp_add_pkg::*; (
    input  logic [SIG_W-1:0] operand_i,
    output logic [LZC_W-1:0] count_o
);

    // scan upward so the highest set bit is the one that sticks.
    always_comb begin
        count_o = LZC_W'(SIG_W); // all zero.
        for (int i = 0; i < SIG_W; i++) begin
            if (operand_i[i]) begin
                count_o = LZC_W'(SIG_W - 1 - i);
            end
        end
    end

endmodule : leading_zero_counter

// File: logic/fp_add_pkg.sv
package fp_add_pkg;

    localparam int EXP_W  = 8;
    localparam int MANT_W = 23;
    localparam int SIG_W  = MANT_W + 1;          // mantissa with hidden bit.
    localparam int LZC_W  = $clog2(SIG_W + 1);  // must hold the all-zero count.
    localparam int STAGES = 4;

    localparam logic [EXP_W-1:0] MAX_EXP = 8'd254; // largest finite biased exponent.
    localparam logic [EXP_W-1:0] MIN_EXP = 8'd1;

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exponent;
        logic [MANT_W-1:0] mantissa;
    } float32_t;

    typedef enum logic {
        ADD = 1'b0,
        SUB = 1'b1
    } fp_op_t;

    // quiet nan, positive, top mantissa bit only.
    localparam float32_t CANONICAL_NAN = {1'b0, {EXP_W{1'b1}}, 1'b1, {(MANT_W-1){1'b0}}};

    typedef struct packed {
        float32_t          major;
        logic              minor_sign;
        logic              minor_hidden;
        logic [MANT_W-1:0] minor_mantissa;
        logic [EXP_W-1:0]  exp_diff;        // absolute exponent difference.
        logic              invalid;
    } cmp_stage_t;

    typedef struct packed {
        float32_t         major;
        logic             minor_sign;
        logic [SIG_W-1:0] minor_aligned;
        logic [SIG_W-1:0] shifted_out;
        logic             invalid;
    } align_stage_t;

    typedef struct packed {
        float32_t         result;
        logic             hidden;
        logic             carry;
        logic             signs_diff;
        logic [SIG_W-1:0] shifted_out;
        logic             invalid;
    } sum_stage_t;

    typedef struct packed {
        float32_t result;
        logic     overflow;
        logic     underflow;
        logic     invalid;
    } norm_stage_t;

endpackage : fp_add_pkg
